// ==== Makefile ====
TOP := tb_acc

.PHONY: compile run clean

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f all.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
src/acc_pkg.sv
src/acc_regfile.sv
src/acc_ctrl.sv
src/acc_addrgen.sv
src/acc_engine.sv
src/acc_top.sv
tb/tb_acc.sv

// ==== src/acc_addrgen.sv ====
// Linear address generator
// One address per step from base, for tot_len elements
module acc_addrgen #(
  parameter int unsigned LEN_W  = 16,
  parameter int unsigned STRIDE = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  acc_pkg::stream_ctrl_t      ctrl_i,
  input  logic                       step_i,
  output logic [acc_pkg::ADDR_W-1:0] addr_o,
  output logic                       valid_o,
  output acc_pkg::stream_flags_t     flags_o
);

  logic                       active_q, done_q;
  logic [LEN_W-1:0]           cnt_q, start_len;
  logic [acc_pkg::ADDR_W-1:0] addr_q;

  assign start_len = ctrl_i.tot_len[LEN_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      cnt_q    <= '0;
      addr_q   <= '0;
    end else begin
      done_q <= 1'b0;
      if (ctrl_i.req_start) begin
        addr_q   <= ctrl_i.base_addr;
        cnt_q    <= start_len;
        active_q <= (start_len != '0);
        done_q   <= (start_len == '0); // Empty pass finishes at once
      end else if (active_q && step_i) begin
        addr_q <= addr_q + acc_pkg::ADDR_W'(STRIDE);
        cnt_q  <= cnt_q - 1'b1;
        if (cnt_q == LEN_W'(1)) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  assign addr_o              = addr_q;
  assign valid_o             = active_q;
  assign flags_o.ready_start = !active_q;
  assign flags_o.done        = done_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_o.done |-> flags_o.ready_start && !valid_o);

endmodule

// ==== src/acc_ctrl.sv ====
// Job controller
// Starts the three streams, reloads weights in two phases and signals done
module acc_ctrl #(
  parameter int unsigned LEN_W = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  acc_pkg::job_cfg_t      cfg_i,
  output acc_pkg::stream_ctrl_t  in_ctrl_o,
  output acc_pkg::stream_ctrl_t  wt_ctrl_o,
  output acc_pkg::stream_ctrl_t  out_ctrl_o,
  input  acc_pkg::stream_flags_t in_flags_i,
  input  acc_pkg::stream_flags_t wt_flags_i,
  input  acc_pkg::stream_flags_t out_flags_i,
  input  logic                   engine_busy_i,
  output logic                   done_o,
  output logic                   clear_o
);

  acc_pkg::ctrl_state_e       state_q, state_d;
  logic                       restart_wt_q, restart_wt_d;
  logic [acc_pkg::ADDR_W-1:0] wt_base_q, wt_base_d;
  logic [LEN_W-1:0]           wt_len_q, wt_len_d;
  logic [LEN_W-1:0]           job_len, half_len;
  logic                       out_fin, dis_fin;

  assign job_len  = cfg_i.len[LEN_W-1:0];
  assign half_len = job_len >> 1;

  // Finish conditions for the two output modes
  assign out_fin = !cfg_i.output_disable && out_flags_i.ready_start && wt_flags_i.ready_start;
  assign dis_fin = cfg_i.output_disable && !engine_busy_i &&
                   in_flags_i.ready_start && wt_flags_i.ready_start;

  always_comb begin
    state_d      = state_q;
    restart_wt_d = 1'b0;
    wt_base_d    = wt_base_q;
    wt_len_d     = wt_len_q;
    in_ctrl_o    = '0;
    wt_ctrl_o    = '0;
    out_ctrl_o   = '0;
    done_o       = 1'b0;
    clear_o      = 1'b0;

    case (state_q)
      acc_pkg::CtrlIdle: begin
        if (start_i) begin
          state_d              = cfg_i.next_load ? acc_pkg::CtrlNextLoad : acc_pkg::CtrlDone;
          in_ctrl_o.req_start  = 1'b1;
          out_ctrl_o.req_start = !cfg_i.output_disable;
          restart_wt_d         = 1'b1;
          wt_base_d            = cfg_i.weight_ptr0;
          wt_len_d             = cfg_i.next_load ? half_len : job_len;
        end
      end
      acc_pkg::CtrlNextLoad: begin
        if (wt_flags_i.done) begin
          state_d      = acc_pkg::CtrlDone;
          restart_wt_d = 1'b1;
          wt_base_d    = cfg_i.weight_ptr1;
          wt_len_d     = job_len - half_len; // Odd element goes to the second half
        end
      end
      acc_pkg::CtrlDone: begin
        // Weight flags are stale while a restart is in flight
        if (!restart_wt_q && (out_fin || dis_fin)) begin
          state_d = acc_pkg::CtrlIdle;
          done_o  = 1'b1;
          clear_o = 1'b1;
        end
      end
      default: state_d = acc_pkg::CtrlIdle;
    endcase

    in_ctrl_o.base_addr              = cfg_i.input_ptr;
    in_ctrl_o.tot_len[LEN_W-1:0]     = job_len;
    wt_ctrl_o.req_start              = restart_wt_q;
    wt_ctrl_o.base_addr              = wt_base_q;
    wt_ctrl_o.tot_len[LEN_W-1:0]     = wt_len_q;
    out_ctrl_o.base_addr             = cfg_i.output_ptr;
    out_ctrl_o.tot_len[LEN_W-1:0]    = job_len;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= acc_pkg::CtrlIdle;
      restart_wt_q <= 1'b0;
      wt_base_q    <= '0;
      wt_len_q     <= '0;
    end else begin
      state_q      <= state_d;
      restart_wt_q <= restart_wt_d;
      wt_base_q    <= wt_base_d;
      wt_len_q     <= wt_len_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> (state_q == acc_pkg::CtrlDone) ##1 (state_q == acc_pkg::CtrlIdle));

  // Sink generator stays idle for a whole output_disable job
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_i.output_disable |-> !out_ctrl_o.req_start && out_flags_i.ready_start);

endmodule

// ==== src/acc_engine.sv ====
// Multiply and requantize engine
// Two-stage pipeline: input times weight, then scale, shift, offset, saturate
module acc_engine (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       in_valid_i,
  input  logic                       wt_valid_i,
  input  logic [acc_pkg::DATA_W-1:0] rd_data_in_i,
  input  logic [acc_pkg::DATA_W-1:0] rd_data_wt_i,
  input  acc_pkg::requant_t          requant_i,
  input  logic [acc_pkg::ADDR_W-1:0] out_addr_i,
  output acc_pkg::mem_wr_t           wr_o,
  input  logic                       wr_ready_i,
  input  logic                       out_enable_i,
  output logic                       consume_o,
  output logic                       busy_o
);

  logic                       rd_pend_q, s1_valid_q, s2_valid_q;
  logic                       stall, s2_leave;
  logic [1:0]                 held;
  logic signed [15:0]         prod_q;
  logic signed [24:0]         scaled, shifted;
  logic signed [25:0]         sum;
  logic [acc_pkg::DATA_W-1:0] res_d, res_q;

  assign stall    = s2_valid_q & out_enable_i & ~wr_ready_i;
  assign s2_leave = s2_valid_q & ~stall;

  // Read data is only present for one cycle, so a slot must be free for it
  assign held      = 2'(rd_pend_q) + 2'(s1_valid_q) + 2'(s2_valid_q) - 2'(s2_leave);
  assign consume_o = in_valid_i & wt_valid_i & ~stall & (held < 2'd2);

  always_comb begin
    scaled  = prod_q * $signed({1'b0, requant_i.mult});
    shifted = scaled >>> requant_i.shift[4:0];
    sum     = shifted + $signed(requant_i.add);
    if (sum > 26'sd127) begin
      res_d = 8'h7f;
    end else if (sum < -26'sd128) begin
      res_d = 8'h80;
    end else begin
      res_d = sum[7:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q  <= 1'b0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      rd_pend_q <= consume_o;
      if (rd_pend_q) begin
        s1_valid_q <= 1'b1;
      end else if (!stall) begin
        s1_valid_q <= 1'b0;
      end
      if (!stall) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_pend_q) begin
      prod_q <= $signed(rd_data_in_i) * $signed(rd_data_wt_i);
    end
    if (!stall && s1_valid_q) begin
      res_q <= res_d;
    end
  end

  assign wr_o.valid = s2_valid_q & out_enable_i; // Dropped when output is off
  assign wr_o.addr  = out_addr_i;
  assign wr_o.data  = res_q;
  assign busy_o     = rd_pend_q | s1_valid_q | s2_valid_q;

  // Returning data always finds stage 1 free or draining
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_pend_q |-> !s1_valid_q || !stall);

endmodule

// ==== src/acc_pkg.sv ====
// Vector accelerator package
// Widths, register map, FSM states and the structs shared by the RTL
package acc_pkg;

  localparam int unsigned DATA_W = 8;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned REG_W  = 32;

  typedef enum logic [3:0] {
    RegCtrl       = 4'd0, // bit0 next_load, bit1 output_disable
    RegInputPtr   = 4'd1,
    RegWeightPtr0 = 4'd2,
    RegWeightPtr1 = 4'd3,
    RegOutputPtr  = 4'd4,
    RegRequant    = 4'd5, // mult 7:0, shift 15:8, add 23:16
    RegLen        = 4'd6,
    RegTrigger    = 4'd7, // write-only
    RegStatus     = 4'd8  // read-only, bit0 busy
  } reg_idx_e;

  typedef enum logic [1:0] {
    CtrlIdle,
    CtrlNextLoad,
    CtrlDone
  } ctrl_state_e;

  typedef struct packed {
    logic             req;
    logic             we;
    logic [3:0]       addr;
    logic [REG_W-1:0] wdata;
  } periph_req_t;

  typedef struct packed {
    logic             gnt;
    logic             rvalid;
    logic [REG_W-1:0] rdata;
  } periph_rsp_t;

  typedef struct packed {
    logic              next_load;
    logic              output_disable;
    logic [ADDR_W-1:0] input_ptr;
    logic [ADDR_W-1:0] weight_ptr0;
    logic [ADDR_W-1:0] weight_ptr1;
    logic [ADDR_W-1:0] output_ptr;
    logic [15:0]       len;
  } job_cfg_t;

  typedef struct packed {
    logic        [7:0] mult;
    logic        [7:0] shift; // Only 4:0 used
    logic signed [7:0] add;
  } requant_t;

  typedef struct packed {
    logic              req_start;
    logic [ADDR_W-1:0] base_addr;
    logic [15:0]       tot_len;
  } stream_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
  } stream_flags_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mem_rd_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_wr_t;

endpackage

// ==== src/acc_regfile.sv ====
// Accelerator register file
// Peripheral bus slave holding the job setup, with start, busy and event
module acc_regfile #(
  parameter int unsigned LEN_W = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  acc_pkg::periph_req_t periph_req_i,
  output acc_pkg::periph_rsp_t periph_rsp_o,
  input  logic                 done_i,
  output logic                 start_o,
  output logic                 busy_o,
  output logic                 evt_o,
  output acc_pkg::job_cfg_t    cfg_o,
  output acc_pkg::requant_t    requant_o
);

  logic                       wr_en, rd_en;
  acc_pkg::reg_idx_e          idx;
  logic [1:0]                 ctrl_q;
  logic [acc_pkg::ADDR_W-1:0] input_ptr_q, weight_ptr0_q, weight_ptr1_q, output_ptr_q;
  acc_pkg::requant_t          requant_q;
  logic [LEN_W-1:0]           len_q;
  logic                       start_q, busy_q, evt_q, rvalid_q;
  logic [acc_pkg::REG_W-1:0]  rdata_d, rdata_q;

  assign wr_en = periph_req_i.req & periph_req_i.we;
  assign rd_en = periph_req_i.req & ~periph_req_i.we;
  assign idx   = acc_pkg::reg_idx_e'(periph_req_i.addr);

  always_comb begin
    rdata_d = '0;
    case (idx)
      acc_pkg::RegCtrl:       rdata_d[1:0] = ctrl_q;
      acc_pkg::RegInputPtr:   rdata_d = input_ptr_q;
      acc_pkg::RegWeightPtr0: rdata_d = weight_ptr0_q;
      acc_pkg::RegWeightPtr1: rdata_d = weight_ptr1_q;
      acc_pkg::RegOutputPtr:  rdata_d = output_ptr_q;
      acc_pkg::RegRequant:    rdata_d[23:0] = {requant_q.add, requant_q.shift, requant_q.mult};
      acc_pkg::RegLen:        rdata_d[LEN_W-1:0] = len_q;
      acc_pkg::RegStatus:     rdata_d[0] = busy_q;
      default:                rdata_d = '0; // Trigger reads as zero
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q        <= '0;
      input_ptr_q   <= '0;
      weight_ptr0_q <= '0;
      weight_ptr1_q <= '0;
      output_ptr_q  <= '0;
      requant_q     <= '0;
      len_q         <= '0;
      start_q       <= 1'b0;
      busy_q        <= 1'b0;
      evt_q         <= 1'b0;
      rvalid_q      <= 1'b0;
    end else begin
      start_q  <= 1'b0;
      evt_q    <= done_i;
      rvalid_q <= rd_en;
      if (done_i) begin
        busy_q <= 1'b0;
      end
      // Whole map is locked while a job runs, trigger included
      if (wr_en && !busy_q) begin
        case (idx)
          acc_pkg::RegCtrl:       ctrl_q        <= periph_req_i.wdata[1:0];
          acc_pkg::RegInputPtr:   input_ptr_q   <= periph_req_i.wdata;
          acc_pkg::RegWeightPtr0: weight_ptr0_q <= periph_req_i.wdata;
          acc_pkg::RegWeightPtr1: weight_ptr1_q <= periph_req_i.wdata;
          acc_pkg::RegOutputPtr:  output_ptr_q  <= periph_req_i.wdata;
          acc_pkg::RegRequant: begin
            requant_q.mult  <= periph_req_i.wdata[7:0];
            requant_q.shift <= periph_req_i.wdata[15:8];
            requant_q.add   <= periph_req_i.wdata[23:16];
          end
          acc_pkg::RegLen:        len_q         <= periph_req_i.wdata[LEN_W-1:0];
          acc_pkg::RegTrigger: begin
            start_q <= 1'b1;
            busy_q  <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign periph_rsp_o.gnt    = periph_req_i.req;
  assign periph_rsp_o.rvalid = rvalid_q;
  assign periph_rsp_o.rdata  = rdata_q;

  always_comb begin
    cfg_o                = '0;
    cfg_o.next_load      = ctrl_q[0];
    cfg_o.output_disable = ctrl_q[1];
    cfg_o.input_ptr      = input_ptr_q;
    cfg_o.weight_ptr0    = weight_ptr0_q;
    cfg_o.weight_ptr1    = weight_ptr1_q;
    cfg_o.output_ptr     = output_ptr_q;
    cfg_o.len[LEN_W-1:0] = len_q;
  end

  assign requant_o = requant_q;
  assign start_o   = start_q;
  assign busy_o    = busy_q;
  assign evt_o     = evt_q;

  // A new job may only start from idle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(start_o) |-> !$past(busy_q));

endmodule

// ==== src/acc_top.sv ====
// Vector accelerator top
// Register file, controller, three address generators and the engine
module acc_top #(
  parameter int unsigned LEN_W = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  acc_pkg::periph_req_t       periph_req_i,
  output acc_pkg::periph_rsp_t       periph_rsp_o,
  output acc_pkg::mem_rd_t           mem_rd_in_o,
  output acc_pkg::mem_rd_t           mem_rd_wt_o,
  input  logic [acc_pkg::DATA_W-1:0] mem_rd_in_data_i,
  input  logic [acc_pkg::DATA_W-1:0] mem_rd_wt_data_i,
  output acc_pkg::mem_wr_t           mem_wr_o,
  input  logic                       mem_wr_ready_i,
  output logic                       busy_o,
  output logic                       evt_o
);

  logic                       start, done, clear, consume, engine_busy, wr_accept;
  acc_pkg::job_cfg_t          cfg;
  acc_pkg::requant_t          requant;
  acc_pkg::stream_ctrl_t      in_ctrl, wt_ctrl, out_ctrl;
  acc_pkg::stream_flags_t     in_flags, wt_flags, out_flags;
  logic [acc_pkg::ADDR_W-1:0] in_addr, wt_addr, out_addr;
  logic                       in_valid, wt_valid, out_valid;

  acc_regfile #(.LEN_W(LEN_W)) u_regfile (
    .clk_i, .rst_ni, .periph_req_i, .periph_rsp_o,
    .done_i    (done),
    .start_o   (start),
    .busy_o,
    .evt_o,
    .cfg_o     (cfg),
    .requant_o (requant)
  );

  acc_ctrl #(.LEN_W(LEN_W)) u_ctrl (
    .clk_i, .rst_ni,
    .start_i       (start),
    .cfg_i         (cfg),
    .in_ctrl_o     (in_ctrl),
    .wt_ctrl_o     (wt_ctrl),
    .out_ctrl_o    (out_ctrl),
    .in_flags_i    (in_flags),
    .wt_flags_i    (wt_flags),
    .out_flags_i   (out_flags),
    .engine_busy_i (engine_busy),
    .done_o        (done),
    .clear_o       (clear)
  );

  acc_addrgen #(.LEN_W(LEN_W), .STRIDE(1)) u_in_gen (
    .clk_i, .rst_ni, .ctrl_i(in_ctrl), .step_i(consume),
    .addr_o(in_addr), .valid_o(in_valid), .flags_o(in_flags)
  );

  acc_addrgen #(.LEN_W(LEN_W), .STRIDE(1)) u_wt_gen (
    .clk_i, .rst_ni, .ctrl_i(wt_ctrl), .step_i(consume),
    .addr_o(wt_addr), .valid_o(wt_valid), .flags_o(wt_flags)
  );

  assign wr_accept = mem_wr_o.valid & mem_wr_ready_i;

  acc_addrgen #(.LEN_W(LEN_W), .STRIDE(1)) u_out_gen (
    .clk_i, .rst_ni, .ctrl_i(out_ctrl), .step_i(wr_accept),
    .addr_o(out_addr), .valid_o(out_valid), .flags_o(out_flags)
  );

  // Sink stays idle under output_disable, so results are dropped
  acc_engine u_engine (
    .clk_i, .rst_ni,
    .in_valid_i   (in_valid),
    .wt_valid_i   (wt_valid),
    .rd_data_in_i (mem_rd_in_data_i),
    .rd_data_wt_i (mem_rd_wt_data_i),
    .requant_i    (requant),
    .out_addr_i   (out_addr),
    .wr_o         (mem_wr_o),
    .wr_ready_i   (mem_wr_ready_i),
    .out_enable_i (out_valid),
    .consume_o    (consume),
    .busy_o       (engine_busy)
  );

  assign mem_rd_in_o.valid = consume;
  assign mem_rd_in_o.addr  = in_addr;
  assign mem_rd_wt_o.valid = consume;
  assign mem_rd_wt_o.addr  = wt_addr;

  // End of job leaves the engine drained and raises the event next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear |-> !engine_busy ##1 (evt_o && !busy_o));

endmodule

// ==== tb/tb_acc.sv ====
// Testbench for the vector accelerator
// Peripheral bus tasks, a byte memory model with address and data checks,
// and six directed tests over the job controller and the engine
module tb_acc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int LEN_BASIC    = 16;
  localparam int LEN_SPLIT    = 15; // Odd, second weight pass gets the extra element
  localparam int TOTAL_LEN    = 4 * LEN_BASIC + LEN_SPLIT;
  localparam int WATCHDOG_CYC = TOTAL_LEN * 4 + 1000;
  localparam logic [31:0] IN_PTR  = 32'h40;
  localparam logic [31:0] WT_PTR0 = 32'h80;
  localparam logic [31:0] WT_PTR1 = 32'hc0;

  logic                 clk_i, rst_ni;
  acc_pkg::periph_req_t periph_req_i;
  acc_pkg::periph_rsp_t periph_rsp_o;
  acc_pkg::mem_rd_t     mem_rd_in_o, mem_rd_wt_o;
  acc_pkg::mem_wr_t     mem_wr_o;
  logic [7:0]           mem_rd_in_data_i = 8'h00;
  logic [7:0]           mem_rd_wt_data_i = 8'h00;
  logic                 mem_wr_ready_i = 1'b1;
  logic                 busy_o, evt_o;

  logic [7:0]  mem [1024];
  logic [7:0]  exp_out [64];
  logic [31:0] rd_in_addr_q = '0;
  logic [31:0] rd_wt_addr_q = '0;
  logic [31:0] job_op;
  int          job_len = 0, job_half = 0;
  bit          job_out_dis = 1'b0, rand_ready = 1'b0;
  int          in_cnt = 0, wt_cnt = 0, wr_cnt = 0, evt_cnt = 0;
  int          in_base, wt_base, wr_base, evt_base;
  int          test_errs = 0, chk_errs = 0, tests_run = 0, tests_passed = 0, mark;

  acc_top #(.LEN_W(16)) u_dut (
    .clk_i, .rst_ni, .periph_req_i, .periph_rsp_o, .mem_rd_in_o, .mem_rd_wt_o,
    .mem_rd_in_data_i, .mem_rd_wt_data_i, .mem_wr_o, .mem_wr_ready_i, .busy_o, .evt_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [9:0] byte_idx(logic [31:0] a);
    return a[9:0];
  endfunction

  function automatic logic [7:0] fill_byte(logic [31:0] a);
    return 8'h5a ^ a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
  endfunction

  // Product, scale, arithmetic shift, offset, then clamp to signed 8 bits
  function automatic logic [7:0] requant(logic [7:0] x, logic [7:0] w, acc_pkg::requant_t rq);
    int p;
    p = int'($signed(x)) * int'($signed(w));
    p = p * int'(rq.mult);
    p = p >>> rq.shift[4:0];
    p = p + int'(rq.add);
    if (p > 127) return 8'h7f;
    if (p < -128) return 8'h80;
    return 8'(p);
  endfunction

  function automatic int report_mismatch(string sig, logic [31:0] got, logic [31:0] want);
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, sig, got, want);
    return 1;
  endfunction

  function automatic int report_error(string msg);
    $display("error at %0t ns: %s", $time, msg);
    return 1;
  endfunction

  function automatic int total_errs();
    return test_errs + chk_errs;
  endfunction

  // Memory model, answers reads one cycle late and checks every access
  always @(posedge clk_i) begin : mem_model
    int          k;
    logic [31:0] want_a;
    rd_in_addr_q <= mem_rd_in_o.addr;
    rd_wt_addr_q <= mem_rd_wt_o.addr;
    if (rst_ni) begin
      if (mem_rd_in_o.valid) begin
        k = in_cnt - in_base;
        assert (k < job_len && mem_rd_in_o.addr == IN_PTR + 32'(k))
          else chk_errs += report_mismatch("mem_rd_in_o.addr", mem_rd_in_o.addr, IN_PTR + 32'(k));
        in_cnt <= in_cnt + 1;
      end
      if (mem_rd_wt_o.valid) begin
        k = wt_cnt - wt_base;
        want_a = (k < job_half) ? WT_PTR0 + 32'(k) : WT_PTR1 + 32'(k - job_half);
        assert (k < job_len && mem_rd_wt_o.addr == want_a)
          else chk_errs += report_mismatch("mem_rd_wt_o.addr", mem_rd_wt_o.addr, want_a);
        wt_cnt <= wt_cnt + 1;
      end
      if (mem_wr_o.valid && job_out_dis)
        chk_errs += report_error("mem_wr_o.valid raised while output is disabled");
      if (mem_wr_o.valid && mem_wr_ready_i) begin
        k = wr_cnt - wr_base;
        assert (k < job_len && mem_wr_o.addr == job_op + 32'(k))
          else chk_errs += report_mismatch("mem_wr_o.addr", mem_wr_o.addr, job_op + 32'(k));
        if (k < job_len)
          assert (mem_wr_o.data == exp_out[6'(k)])
            else chk_errs += report_mismatch("mem_wr_o.data", 32'(mem_wr_o.data),
                                             32'(exp_out[6'(k)]));
        mem[byte_idx(mem_wr_o.addr)] = mem_wr_o.data;
        wr_cnt <= wr_cnt + 1;
      end
      if (evt_o) evt_cnt <= evt_cnt + 1;
    end
  end

  always @(negedge clk_i) begin
    mem_rd_in_data_i <= mem[byte_idx(rd_in_addr_q)];
    mem_rd_wt_data_i <= mem[byte_idx(rd_wt_addr_q)];
    mem_wr_ready_i   <= rand_ready ? 1'($urandom_range(1)) : 1'b1;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_wr_o.valid && !mem_wr_ready_i |=> $stable(mem_wr_o))
    else chk_errs += report_error("mem_wr_o changed while mem_wr_ready_i was low");

  assert property (@(posedge clk_i) disable iff (!rst_ni) evt_o |=> !evt_o)
    else chk_errs += report_error("evt_o stayed high for more than one cycle");

  // Busy drops exactly in the cycle of the event pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) evt_o == $fell(busy_o))
    else chk_errs += report_error("busy_o did not fall together with evt_o");

  // Bus tasks start and end on a falling edge
  task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
    periph_req_i.req   = 1'b1;
    periph_req_i.we    = 1'b1;
    periph_req_i.addr  = addr;
    periph_req_i.wdata = data;
    @(posedge clk_i);
    if (!periph_rsp_o.gnt) test_errs += report_error("write request was not granted");
    @(negedge clk_i);
    periph_req_i.req = 1'b0;
    periph_req_i.we  = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
    periph_req_i.req  = 1'b1;
    periph_req_i.we   = 1'b0;
    periph_req_i.addr = addr;
    @(posedge clk_i);
    @(negedge clk_i);
    periph_req_i.req = 1'b0;
    if (!periph_rsp_o.rvalid) test_errs += report_error("no rvalid one cycle after a read");
    data = periph_rsp_o.rdata;
  endtask

  task automatic expect_reg(input logic [3:0] addr, input logic [31:0] want);
    logic [31:0] got;
    bus_read(addr, got);
    if (got !== want)
      test_errs += report_mismatch($sformatf("periph_rsp_o.rdata (reg %0d)", addr), got, want);
  endtask

  task automatic write_readback(input logic [3:0] addr, input logic [31:0] data,
                                input logic [31:0] want);
    bus_write(addr, data);
    expect_reg(addr, want);
  endtask

  task automatic run_job(input int len, input bit next_load, input bit out_dis,
                         input logic [31:0] out_ptr, input bit protect);
    acc_pkg::requant_t rq;
    logic [7:0]        wt, want;
    int                cyc;
    rq.mult  = 8'($urandom());
    rq.shift = 8'($urandom_range(12));
    rq.add   = 8'($urandom());
    for (int i = 0; i < len; i++) begin
      mem[byte_idx(IN_PTR + 32'(i))]  = 8'($urandom());
      mem[byte_idx(WT_PTR0 + 32'(i))] = 8'($urandom());
      mem[byte_idx(WT_PTR1 + 32'(i))] = 8'($urandom());
    end
    job_len     = len;
    job_half    = next_load ? len / 2 : len;
    job_out_dis = out_dis;
    job_op      = out_ptr;
    for (int i = 0; i < len; i++) begin
      wt = (i < job_half) ? mem[byte_idx(WT_PTR0 + 32'(i))]
                          : mem[byte_idx(WT_PTR1 + 32'(i - job_half))];
      exp_out[6'(i)] = requant(mem[byte_idx(IN_PTR + 32'(i))], wt, rq);
    end
    bus_write(acc_pkg::RegCtrl, {30'd0, out_dis, next_load});
    bus_write(acc_pkg::RegInputPtr, IN_PTR);
    bus_write(acc_pkg::RegWeightPtr0, WT_PTR0);
    bus_write(acc_pkg::RegWeightPtr1, WT_PTR1);
    bus_write(acc_pkg::RegOutputPtr, out_ptr);
    bus_write(acc_pkg::RegRequant, {8'h00, rq.add, rq.shift, rq.mult});
    bus_write(acc_pkg::RegLen, 32'(len));
    in_base  = in_cnt;
    wt_base  = wt_cnt;
    wr_base  = wr_cnt;
    evt_base = evt_cnt;
    bus_write(acc_pkg::RegTrigger, 32'd1);
    if (protect) begin
      bus_write(acc_pkg::RegLen, 32'd3); // Must be dropped, job is running
      expect_reg(acc_pkg::RegStatus, 32'd1);
    end
    cyc = 0;
    while (!evt_o && cyc < len * 8 + 100) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!evt_o) test_errs += report_error("job never raised evt_o");
    repeat (3) @(negedge clk_i);
    if (evt_cnt - evt_base != 1)
      test_errs += report_mismatch("evt_o pulse count", 32'(evt_cnt - evt_base), 32'd1);
    if (in_cnt - in_base != len)
      test_errs += report_mismatch("mem_rd_in_o count", 32'(in_cnt - in_base), 32'(len));
    if (wt_cnt - wt_base != len)
      test_errs += report_mismatch("mem_rd_wt_o count", 32'(wt_cnt - wt_base), 32'(len));
    if (wr_cnt - wr_base != (out_dis ? 0 : len))
      test_errs += report_mismatch("mem_wr_o count", 32'(wr_cnt - wr_base),
                                   out_dis ? 32'd0 : 32'(len));
    for (int i = 0; i < len; i++) begin
      want = out_dis ? fill_byte(out_ptr + 32'(i)) : exp_out[6'(i)];
      if (mem[byte_idx(out_ptr + 32'(i))] !== want)
        test_errs += report_mismatch($sformatf("mem[%0h]", out_ptr + 32'(i)),
                                     32'(mem[byte_idx(out_ptr + 32'(i))]), 32'(want));
    end
    if (protect) expect_reg(acc_pkg::RegLen, 32'(len));
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    int errs;
    errs = total_errs() - errs_before;
    tests_run++;
    if (errs == 0) tests_passed++;
    $display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "PASS" : "FAIL", errs);
  endtask

  initial begin
    rst_ni       = 1'b0;
    periph_req_i = '0;
    void'($urandom(39));
    for (int a = 0; a < 1024; a++) mem[a[9:0]] = fill_byte(32'(a));
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    mark = total_errs();
    if (busy_o || evt_o || mem_rd_in_o.valid || mem_rd_wt_o.valid || mem_wr_o.valid)
      test_errs += report_error("outputs not idle after reset");
    expect_reg(acc_pkg::RegStatus, 32'd0);
    write_readback(acc_pkg::RegCtrl, 32'h0000_0002, 32'h0000_0002);
    write_readback(acc_pkg::RegInputPtr, 32'h1234_5678, 32'h1234_5678);
    write_readback(acc_pkg::RegWeightPtr0, 32'h8765_4321, 32'h8765_4321);
    write_readback(acc_pkg::RegWeightPtr1, 32'hcafe_0042, 32'hcafe_0042);
    write_readback(acc_pkg::RegOutputPtr, 32'h0bad_f00d, 32'h0bad_f00d);
    write_readback(acc_pkg::RegRequant, 32'hff12_3456, 32'h0012_3456);
    write_readback(acc_pkg::RegLen, 32'hdead_0009, 32'h0000_0009);
    end_test(1, "register read-back", mark);

    mark = total_errs();
    run_job(LEN_BASIC, 1'b0, 1'b0, 32'h100, 1'b0);
    end_test(2, "basic job", mark);

    mark = total_errs();
    run_job(LEN_SPLIT, 1'b1, 1'b0, 32'h140, 1'b0);
    end_test(3, "next load", mark);

    mark = total_errs();
    run_job(LEN_BASIC, 1'b0, 1'b1, 32'h180, 1'b0);
    end_test(4, "output disable", mark);

    mark = total_errs();
    rand_ready = 1'b1;
    run_job(LEN_BASIC, 1'b0, 1'b0, 32'h1c0, 1'b0);
    rand_ready = 1'b0;
    end_test(5, "back-pressure", mark);

    mark = total_errs();
    run_job(LEN_BASIC, 1'b0, 1'b0, 32'h200, 1'b1);
    end_test(6, "busy protection", mark);

    $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, total_errs());
    if (total_errs() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
    $display("Testbench failed");
    $finish;
  end

endmodule
